// ==== rtl/lsu_pkg.sv ====
// load/store unit shared definitions
// bus word and lane types, access sizes

package lsu_pkg;

  ////////////////////////////////////////
  // bus geometry
  ////////////////////////////////////////

  // bytes carried by one bus word
  localparam int unsigned BusBytes  = 4;
  // bits in one bus word
  localparam int unsigned WordWidth = 8 * BusBytes;

  // one bus data word
  typedef logic [WordWidth-1:0] word_t;

  // one enable per byte lane
  typedef logic [BusBytes-1:0] be_t;

  // byte offset within a word
  typedef logic [$clog2(BusBytes)-1:0] offset_t;

  ////////////////////////////////////////
  // access size
  ////////////////////////////////////////

  // code 2'b11 is never issued by the core
  typedef enum logic [1:0] {
    LSU_WORD = 2'b00,
    LSU_HALF = 2'b01,
    LSU_BYTE = 2'b10
  } lsu_type_e;

endpackage

// ==== rtl/lsu_wdata_align.sv ====
// store path of the load/store unit
// byte enables per access part and store data rotation into lanes

module lsu_wdata_align import lsu_pkg::*; (
  input  lsu_type_e lsu_type_i,
  input  offset_t   offset_i,
  input  logic      second_part_i,
  input  word_t     lsu_wdata_i,
  output be_t       data_be_o,
  output word_t     data_wdata_o
);

  // lanes touched by the access, before the shift
  be_t                   size_mask;
  // enables over two adjacent words, low half is the first word
  logic [2*BusBytes-1:0] be_span;

  ////////////////////////////////////////
  // byte enables
  ////////////////////////////////////////

  always_comb begin
    unique case (lsu_type_i)
      LSU_WORD: size_mask = 4'b1111;
      LSU_HALF: size_mask = 4'b0011;
      LSU_BYTE: size_mask = 4'b0001;
      // unused code, treat as full word
      default:  size_mask = 4'b1111;
    endcase
  end

  // shift the size mask up to the start lane
  // bits that fall past lane 3 belong to the next word
  assign be_span = {{BusBytes{1'b0}}, size_mask} << offset_i;

  // second part only gets the overflowed low lanes
  assign data_be_o = second_part_i ? be_span[2*BusBytes-1:BusBytes] : be_span[BusBytes-1:0];

  ////////////////////////////////////////
  // store data rotation
  ////////////////////////////////////////

  // rotate left by the offset so byte 0 sits in lane offset
  // bytes wrapping into the low lanes serve the second part
  always_comb begin
    unique case (offset_i)
      2'd0: data_wdata_o = lsu_wdata_i;
      2'd1: data_wdata_o = {lsu_wdata_i[23:0], lsu_wdata_i[31:24]};
      2'd2: data_wdata_o = {lsu_wdata_i[15:0], lsu_wdata_i[31:16]};
      2'd3: data_wdata_o = {lsu_wdata_i[7:0], lsu_wdata_i[31:8]};
    endcase
  end

  // second part is only raised for a split, so some lane always overflows
  a_be_nonzero: assert final (
    $isunknown({lsu_type_i, offset_i, second_part_i}) || (data_be_o != '0)
  ) else $error("byte enables are zero");

endmodule

// ==== rtl/lsu_rdata_align.sv ====
// load path of the load/store unit
// holds the transaction fields and the first word of a split load,
// realigns the returned bytes and extends half-words and bytes

module lsu_rdata_align import lsu_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      ctrl_update_i,
  input  logic      rdata_update_i,
  input  lsu_type_e lsu_type_i,
  input  logic      lsu_sign_ext_i,
  input  offset_t   offset_i,
  input  word_t     data_rdata_i,
  output word_t     lsu_rdata_o
);

  // fields captured at the first grant
  lsu_type_e   type_q;
  logic        sign_ext_q;
  offset_t     offset_q;

  // upper three bytes of the first word of a split load
  logic [31:8] rdata_q;

  // raw loaded values before extension
  word_t       rdata_w;
  logic [15:0] rdata_h;
  logic [7:0]  rdata_b;

  ////////////////////////////////////////
  // capture registers
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      type_q     <= LSU_WORD;
      sign_ext_q <= 1'b0;
      offset_q   <= '0;
    end else if (ctrl_update_i) begin
      type_q     <= lsu_type_i;
      sign_ext_q <= lsu_sign_ext_i;
      offset_q   <= offset_i;
    end
  end

  // lane 0 of the first word is never part of a split load
  always_ff @(posedge clk_i) begin
    if (rdata_update_i) begin
      rdata_q <= data_rdata_i[31:8];
    end
  end

  ////////////////////////////////////////
  // realignment
  ////////////////////////////////////////

  // low bytes come from the stored word, high bytes from the final word
  always_comb begin
    unique case (offset_q)
      2'd0: rdata_w = data_rdata_i;
      2'd1: rdata_w = {data_rdata_i[7:0], rdata_q[31:8]};
      2'd2: rdata_w = {data_rdata_i[15:0], rdata_q[31:16]};
      2'd3: rdata_w = {data_rdata_i[23:0], rdata_q[31:24]};
    endcase
  end

  // a half-word at offset 3 straddles two words
  always_comb begin
    unique case (offset_q)
      2'd0: rdata_h = data_rdata_i[15:0];
      2'd1: rdata_h = data_rdata_i[23:8];
      2'd2: rdata_h = data_rdata_i[31:16];
      2'd3: rdata_h = {data_rdata_i[7:0], rdata_q[31:24]};
    endcase
  end

  // a byte is always inside the final word
  assign rdata_b = data_rdata_i[8*offset_q +: 8];

  ////////////////////////////////////////
  // extension
  ////////////////////////////////////////

  always_comb begin
    unique case (type_q)
      LSU_HALF: lsu_rdata_o = {{16{sign_ext_q & rdata_h[15]}}, rdata_h};
      LSU_BYTE: lsu_rdata_o = {{24{sign_ext_q & rdata_b[7]}}, rdata_b};
      default:  lsu_rdata_o = rdata_w;
    endcase
  end

  // size select must never go X once out of reset
  a_type_known: assert property (@(posedge clk_i) disable iff (!rst_ni) !$isunknown(type_q))
    else $error("captured access size unknown");

endmodule

// ==== rtl/lsu_ctrl_fsm.sv ====
// bus control for the load/store unit
// splits misaligned accesses into two word requests, tracks grants
// and rvalids, and forms the response, error and last-address outputs

module lsu_ctrl_fsm import lsu_pkg::*; #(
  parameter int unsigned AddrWidth = 32
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 lsu_req_i,
  input  logic                 lsu_we_i,
  input  lsu_type_e            lsu_type_i,
  input  logic [AddrWidth-1:0] lsu_addr_i,
  input  logic                 data_gnt_i,
  input  logic                 data_rvalid_i,
  input  logic                 data_bus_err_i,
  output logic                 data_req_o,
  output logic [AddrWidth-1:0] data_addr_o,
  output logic                 second_part_o,
  output logic                 ctrl_update_o,
  output logic                 rdata_update_o,
  output logic                 lsu_req_done_o,
  output logic                 lsu_resp_valid_o,
  output logic                 lsu_rdata_valid_o,
  output logic                 load_err_o,
  output logic                 store_err_o,
  output logic [AddrWidth-1:0] addr_last_o,
  output logic                 busy_o
);

  typedef enum logic [2:0] {
    IDLE,
    WAIT_GNT_MIS,
    WAIT_RVALID_MIS,
    WAIT_GNT,
    WAIT_RVALID_MIS_GNTS_DONE
  } ls_fsm_e;

  ls_fsm_e              ls_fsm_cs, ls_fsm_ns;

  offset_t              data_offset;
  logic [AddrWidth-1:0] addr_word;
  logic [AddrWidth-1:0] addr_next_word;
  logic                 split_access;
  // select the second word address
  logic                 addr_incr;

  logic                 second_part_q, second_part_d;
  logic                 lsu_err_q, lsu_err_d;
  logic                 data_we_q;
  logic                 data_err;

  logic                 addr_update;
  logic [AddrWidth-1:0] addr_last_q, addr_last_d;

  ////////////////////////////////////////
  // address generation
  ////////////////////////////////////////

  assign data_offset    = lsu_addr_i[1:0];
  assign addr_word      = {lsu_addr_i[AddrWidth-1:2], 2'b00};
  assign addr_next_word = addr_word + AddrWidth'(BusBytes);
  assign data_addr_o    = addr_incr ? addr_next_word : addr_word;

  // word at any non-zero offset, or half-word in the top lane
  assign split_access = ((lsu_type_i == LSU_WORD) && (data_offset != 2'd0)) ||
                        ((lsu_type_i == LSU_HALF) && (data_offset == 2'd3));

  ////////////////////////////////////////
  // state machine
  ////////////////////////////////////////

  always_comb begin
    ls_fsm_ns      = ls_fsm_cs;
    data_req_o     = 1'b0;
    addr_incr      = 1'b0;
    second_part_d  = second_part_q;
    lsu_err_d      = lsu_err_q;
    addr_update    = 1'b0;
    ctrl_update_o  = 1'b0;
    rdata_update_o = 1'b0;

    unique case (ls_fsm_cs)
      IDLE: begin
        if (lsu_req_i) begin
          data_req_o = 1'b1;
          lsu_err_d  = 1'b0;
          if (data_gnt_i) begin
            ctrl_update_o = 1'b1;
            addr_update   = 1'b1;
            second_part_d = split_access;
            ls_fsm_ns     = split_access ? WAIT_RVALID_MIS : IDLE;
          end else begin
            ls_fsm_ns     = split_access ? WAIT_GNT_MIS : WAIT_GNT;
          end
        end
      end

      WAIT_GNT_MIS: begin
        data_req_o = 1'b1;
        if (data_gnt_i) begin
          ctrl_update_o = 1'b1;
          addr_update   = 1'b1;
          second_part_d = 1'b1;
          ls_fsm_ns     = WAIT_RVALID_MIS;
        end
      end

      WAIT_RVALID_MIS: begin
        // second request goes out while the first response is pending
        data_req_o = 1'b1;
        addr_incr  = 1'b1;
        if (data_rvalid_i) begin
          lsu_err_d      = data_bus_err_i;
          rdata_update_o = ~data_we_q;
          // a first-part error keeps the failing address
          addr_update    = data_gnt_i & ~data_bus_err_i;
          second_part_d  = ~data_gnt_i;
          ls_fsm_ns      = data_gnt_i ? IDLE : WAIT_GNT;
        end else if (data_gnt_i) begin
          second_part_d = 1'b0;
          ls_fsm_ns     = WAIT_RVALID_MIS_GNTS_DONE;
        end
      end

      WAIT_GNT: begin
        // shared by a stalled aligned access and a stalled second part
        data_req_o = 1'b1;
        addr_incr  = second_part_q;
        if (data_gnt_i) begin
          ctrl_update_o = ~second_part_q;
          addr_update   = ~lsu_err_q;
          second_part_d = 1'b0;
          ls_fsm_ns     = IDLE;
        end
      end

      WAIT_RVALID_MIS_GNTS_DONE: begin
        // both granted, the address still points at the second word
        addr_incr = 1'b1;
        if (data_rvalid_i) begin
          lsu_err_d      = data_bus_err_i;
          rdata_update_o = ~data_we_q;
          addr_update    = ~data_bus_err_i;
          ls_fsm_ns      = IDLE;
        end
      end

      default: ls_fsm_ns = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ls_fsm_cs     <= IDLE;
      second_part_q <= 1'b0;
      lsu_err_q     <= 1'b0;
    end else begin
      ls_fsm_cs     <= ls_fsm_ns;
      second_part_q <= second_part_d;
      lsu_err_q     <= lsu_err_d;
    end
  end

  // write flag of the access in flight
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      data_we_q <= 1'b0;
    end else if (ctrl_update_o) begin
      data_we_q <= lsu_we_i;
    end
  end

  // byte address of the first part, word address of the second part
  assign addr_last_d = addr_incr ? addr_next_word : lsu_addr_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      addr_last_q <= '0;
    end else if (addr_update) begin
      addr_last_q <= addr_last_d;
    end
  end

  ////////////////////////////////////////
  // response outputs
  ////////////////////////////////////////

  // final rvalid always arrives back in idle
  assign data_err          = lsu_err_q | data_bus_err_i;
  assign lsu_resp_valid_o  = data_rvalid_i & (ls_fsm_cs == IDLE);
  assign lsu_rdata_valid_o = lsu_resp_valid_o & ~data_err & ~data_we_q;
  assign load_err_o        = lsu_resp_valid_o & data_err & ~data_we_q;
  assign store_err_o       = lsu_resp_valid_o & data_err & data_we_q;

  assign lsu_req_done_o = (lsu_req_i | (ls_fsm_cs != IDLE)) & (ls_fsm_ns == IDLE);
  assign busy_o         = (ls_fsm_cs != IDLE);
  assign second_part_o  = second_part_q;
  assign addr_last_o    = addr_last_q;

  a_state_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ls_fsm_cs inside {IDLE, WAIT_GNT_MIS, WAIT_RVALID_MIS, WAIT_GNT, WAIT_RVALID_MIS_GNTS_DONE})
    else $error("illegal state");

  a_addr_aligned: assert property (@(posedge clk_i) disable iff (!rst_ni)
    data_req_o |-> (data_addr_o[1:0] == 2'b00))
    else $error("bus address not word aligned");

endmodule

// ==== rtl/lsu_top.sv ====
// load/store unit top level
// joins the bus controller with the store and load data paths

module lsu_top import lsu_pkg::*; #(
  parameter int unsigned AddrWidth = 32
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,

  // core side
  input  logic                 lsu_req_i,
  input  logic                 lsu_we_i,
  input  lsu_type_e            lsu_type_i,
  input  logic                 lsu_sign_ext_i,
  input  logic [AddrWidth-1:0] lsu_addr_i,
  input  word_t                lsu_wdata_i,
  output word_t                lsu_rdata_o,
  output logic                 lsu_rdata_valid_o,
  output logic                 lsu_resp_valid_o,
  output logic                 lsu_req_done_o,
  output logic                 load_err_o,
  output logic                 store_err_o,
  output logic [AddrWidth-1:0] addr_last_o,
  output logic                 busy_o,

  // data bus
  output logic                 data_req_o,
  input  logic                 data_gnt_i,
  input  logic                 data_rvalid_i,
  input  logic                 data_bus_err_i,
  output logic [AddrWidth-1:0] data_addr_o,
  output logic                 data_we_o,
  output be_t                  data_be_o,
  output word_t                data_wdata_o,
  input  word_t                data_rdata_i
);

  offset_t lsu_offset;
  logic    second_part;
  logic    ctrl_update;
  logic    rdata_update;

  assign lsu_offset = lsu_addr_i[1:0];
  assign data_we_o  = lsu_we_i;

  lsu_ctrl_fsm #(
    .AddrWidth(AddrWidth)
  ) i_ctrl_fsm (
    .clk_i, .rst_ni, .lsu_req_i, .lsu_we_i, .lsu_type_i, .lsu_addr_i,
    .data_gnt_i, .data_rvalid_i, .data_bus_err_i, .data_req_o, .data_addr_o,
    .second_part_o (second_part),
    .ctrl_update_o (ctrl_update),
    .rdata_update_o(rdata_update),
    .lsu_req_done_o, .lsu_resp_valid_o, .lsu_rdata_valid_o,
    .load_err_o, .store_err_o, .addr_last_o, .busy_o
  );

  lsu_wdata_align i_wdata_align (
    .lsu_type_i, .offset_i(lsu_offset), .second_part_i(second_part),
    .lsu_wdata_i, .data_be_o, .data_wdata_o
  );

  lsu_rdata_align i_rdata_align (
    .clk_i, .rst_ni, .ctrl_update_i(ctrl_update), .rdata_update_i(rdata_update),
    .lsu_type_i, .lsu_sign_ext_i, .offset_i(lsu_offset), .data_rdata_i, .lsu_rdata_o
  );

endmodule

// ==== bench/tb_clk_gen.sv ====
// testbench clock and reset source
// 100 ns clock, active-low reset held for the first cycles

module tb_clk_gen #(
  parameter int unsigned ResetCycles = 4
) (
  output logic clk_o,
  output logic rst_no
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk_o = 1'b0;
    forever #50 clk_o = ~clk_o;
  end

  // release just after a rising edge, like any other stimulus
  initial begin
    rst_no = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    #1 rst_no = 1'b1;
  end

endmodule

// ==== bench/lsu_bus_model.sv ====
// data bus responder for the load/store unit testbench
// byte memory with optional LFSR grant and rvalid delays
// and a window of word addresses that answers with a bus error

module lsu_bus_model import lsu_pkg::*; #(
  parameter int unsigned AddrWidth = 32,
  parameter int unsigned MemBytes  = 64,
  parameter logic [7:0]  Seed      = 8'd83
) (
  input  logic                 clk_i,
  input  logic                 delay_en_i,
  input  logic                 data_req_i,
  input  logic [AddrWidth-1:0] data_addr_i,
  input  logic                 data_we_i,
  input  be_t                  data_be_i,
  input  word_t                data_wdata_i,
  output logic                 data_gnt_o,
  output logic                 data_rvalid_o,
  output logic                 data_bus_err_o,
  output word_t                data_rdata_o,
  output int                   gnt_count_o
);
  timeunit 1ns;
  timeprecision 100ps;

  // error window, words 0x30 and 0x34
  localparam logic [AddrWidth-1:0] ErrLo = 'h30;
  localparam logic [AddrWidth-1:0] ErrHi = 'h37;

  logic [7:0]  mem [MemBytes];
  logic [7:0]  lfsr;
  logic        gnt_pending;
  int unsigned gnt_wait;
  int unsigned cycle;

  // one entry per granted access, popped in grant order
  word_t       rsp_data [$];
  logic        rsp_err  [$];
  int unsigned rsp_due  [$];

  ////////////////////////////////////////
  // random delays
  ////////////////////////////////////////

  // fibonacci form, taps for x^8 + x^6 + x^5 + x^4 + 1
  function automatic logic [7:0] lfsr_next(logic [7:0] state);
    return {state[6:0], state[7] ^ state[5] ^ state[4] ^ state[3]};
  endfunction

  // 0 to 3 cycles, one step per bit
  function automatic int unsigned draw_delay();
    int unsigned d;
    d = 0;
    for (int i = 0; i < 2; i++) begin
      lfsr = lfsr_next(lfsr);
      d    = (d << 1) | lfsr[0];
    end
    return d;
  endfunction

  // every byte holds a value set by its full address
  task automatic fill_mem();
    for (int a = 0; a < MemBytes; a++) begin
      mem[a] = 8'h40 + 8'(a);
    end
  endtask

  ////////////////////////////////////////
  // bus handshake
  ////////////////////////////////////////

  task automatic serve_response();
    data_rvalid_o  = 1'b0;
    data_bus_err_o = 1'b0;
    if ((rsp_due.size() != 0) && (rsp_due[0] <= cycle)) begin
      data_rvalid_o  = 1'b1;
      data_bus_err_o = rsp_err.pop_front();
      data_rdata_o   = rsp_data.pop_front();
      void'(rsp_due.pop_front());
    end
  endtask

  task automatic serve_request();
    int unsigned base;
    logic        err;
    word_t       rdata;
    data_gnt_o = 1'b0;
    if (data_req_i) begin
      // delay is drawn once, when the request first shows up
      if (!gnt_pending) begin
        gnt_wait    = delay_en_i ? draw_delay() : 0;
        gnt_pending = 1'b1;
      end
      if (gnt_wait != 0) begin
        gnt_wait--;
      end else begin
        data_gnt_o  = 1'b1;
        gnt_pending = 1'b0;
        gnt_count_o++;
        base  = data_addr_i % MemBytes;
        err   = (data_addr_i >= ErrLo) && (data_addr_i <= ErrHi);
        rdata = '0;
        for (int b = 0; b < BusBytes; b++) begin
          // failing stores leave memory alone
          if (!err && data_we_i && data_be_i[b]) begin
            mem[base+b] = data_wdata_i[8*b +: 8];
          end
          rdata[8*b +: 8] = mem[base+b];
        end
        rsp_data.push_back(err ? '0 : rdata);
        rsp_err.push_back(err);
        // rvalid at the earliest in the cycle after the grant
        rsp_due.push_back(cycle + 1 + (delay_en_i ? draw_delay() : 0));
      end
    end
  endtask

  initial begin
    data_gnt_o     = 1'b0;
    data_rvalid_o  = 1'b0;
    data_bus_err_o = 1'b0;
    data_rdata_o   = '0;
    gnt_count_o    = 0;
    gnt_pending    = 1'b0;
    gnt_wait       = 0;
    cycle          = 0;
    lfsr           = Seed;
    fill_mem();
    forever begin
      // 2 ns, after the core side has driven its inputs and data_req settled
      @(posedge clk_i);
      #2;
      cycle++;
      serve_response();
      serve_request();
    end
  end

endmodule

// ==== bench/lsu_tb.sv ====
// load/store unit testbench
// applies a table of loads and stores twice, first with an immediate
// bus and then with LFSR-driven grant and rvalid delays

module lsu_tb import lsu_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int unsigned AddrWidth   = 32;
  // cycles allowed per table entry
  localparam int unsigned EntryCycles = 20;

  typedef struct packed {
    logic                 we;
    lsu_type_e            size;
    logic                 sign;
    logic [AddrWidth-1:0] addr;
    word_t                wdata;
    word_t                rdata;
    logic                 err;
    logic [1:0]           parts;
    logic [AddrWidth-1:0] last;
  } entry_t;

  logic                 clk, rst_n;
  logic                 lsu_req, lsu_we, lsu_sign_ext, delay_en;
  lsu_type_e            lsu_type;
  logic [AddrWidth-1:0] lsu_addr, addr_last, data_addr;
  word_t                lsu_wdata, lsu_rdata, data_wdata, data_rdata;
  logic                 lsu_rdata_valid, lsu_resp_valid, lsu_req_done;
  logic                 load_err, store_err, busy;
  logic                 data_req, data_gnt, data_rvalid, data_bus_err, data_we;
  be_t                  data_be;
  int                   gnt_count;

  entry_t      tbl [$];
  int unsigned cycle_limit = 0;
  int          resp_cnt    = 0;
  int          resp_exp    = 0;
  int unsigned err_cnt     = 0;
  int unsigned pass_cnt    = 0;
  int unsigned fail_cnt    = 0;

  tb_clk_gen #(.ResetCycles(4)) i_clk_gen (.clk_o(clk), .rst_no(rst_n));

  lsu_top #(.AddrWidth(AddrWidth)) i_dut (
    .clk_i(clk), .rst_ni(rst_n), .lsu_req_i(lsu_req), .lsu_we_i(lsu_we),
    .lsu_type_i(lsu_type), .lsu_sign_ext_i(lsu_sign_ext), .lsu_addr_i(lsu_addr),
    .lsu_wdata_i(lsu_wdata), .lsu_rdata_o(lsu_rdata), .lsu_rdata_valid_o(lsu_rdata_valid),
    .lsu_resp_valid_o(lsu_resp_valid), .lsu_req_done_o(lsu_req_done),
    .load_err_o(load_err), .store_err_o(store_err), .addr_last_o(addr_last),
    .busy_o(busy), .data_req_o(data_req), .data_gnt_i(data_gnt),
    .data_rvalid_i(data_rvalid), .data_bus_err_i(data_bus_err), .data_addr_o(data_addr),
    .data_we_o(data_we), .data_be_o(data_be), .data_wdata_o(data_wdata),
    .data_rdata_i(data_rdata)
  );

  lsu_bus_model #(.AddrWidth(AddrWidth), .MemBytes(64), .Seed(8'd83)) i_bus (
    .clk_i(clk), .delay_en_i(delay_en), .data_req_i(data_req), .data_addr_i(data_addr),
    .data_we_i(data_we), .data_be_i(data_be), .data_wdata_i(data_wdata),
    .data_gnt_o(data_gnt), .data_rvalid_o(data_rvalid), .data_bus_err_o(data_bus_err),
    .data_rdata_o(data_rdata), .gnt_count_o(gnt_count)
  );

  // every response pulse, wanted or not
  always @(negedge clk) begin
    if (lsu_resp_valid) begin
      resp_cnt++;
    end
  end

  ////////////////////////////////////////
  // compare tasks
  ////////////////////////////////////////

  task automatic check_word(string name, word_t act, word_t exp);
    if (act !== exp) begin
      $display("** Error at %0t: %s = 0x%h, expected 0x%h", $time, name, act, exp);
      err_cnt++;
    end
  endtask

  task automatic check_flag(string name, logic act, logic exp);
    if (act !== exp) begin
      $display("** Error at %0t: %s = %b, expected %b", $time, name, act, exp);
      err_cnt++;
    end
  endtask

  task automatic check_addr(string name, logic [AddrWidth-1:0] act, logic [AddrWidth-1:0] exp);
    if (act !== exp) begin
      $display("** Error at %0t: %s = 0x%h, expected 0x%h", $time, name, act, exp);
      err_cnt++;
    end
  endtask

  task automatic check_count(string name, int act, int exp);
    if (act != exp) begin
      $display("** Error at %0t: %s = %0d, expected %0d", $time, name, act, exp);
      err_cnt++;
    end
  endtask

  task automatic report_test(string name, int unsigned errs_start);
    if (err_cnt == errs_start) begin
      pass_cnt++;
      $display("%-24s pass", name);
    end else begin
      fail_cnt++;
      $display("%-24s fail", name);
    end
  endtask

  ////////////////////////////////////////
  // stimulus table
  ////////////////////////////////////////

  function automatic void add_entry(logic we, lsu_type_e size, logic sign,
      logic [AddrWidth-1:0] addr, word_t wdata, word_t rdata, logic err,
      logic [1:0] parts, logic [AddrWidth-1:0] last);
    entry_t e;
    e = '{we, size, sign, addr, wdata, rdata, err, parts, last};
    tbl.push_back(e);
  endfunction

  // memory starts as 0x40 + byte address
  // columns: we, size, sign, addr, wdata, expected rdata, error, bus accesses, addr_last
  function automatic void build_table();
    // aligned stores and loads, sign and zero extension
    add_entry(1'b1, LSU_WORD, 1'b0, 32'h00, 32'h8765_4321, 32'h0, 1'b0, 2'd1, 32'h00);
    add_entry(1'b0, LSU_WORD, 1'b0, 32'h00, 32'h0, 32'h8765_4321, 1'b0, 2'd1, 32'h00);
    add_entry(1'b1, LSU_HALF, 1'b0, 32'h06, 32'h0000_f0a5, 32'h0, 1'b0, 2'd1, 32'h06);
    add_entry(1'b0, LSU_HALF, 1'b1, 32'h06, 32'h0, 32'hffff_f0a5, 1'b0, 2'd1, 32'h06);
    add_entry(1'b0, LSU_HALF, 1'b0, 32'h06, 32'h0, 32'h0000_f0a5, 1'b0, 2'd1, 32'h06);
    add_entry(1'b1, LSU_BYTE, 1'b0, 32'h09, 32'h0000_0096, 32'h0, 1'b0, 2'd1, 32'h09);
    add_entry(1'b0, LSU_BYTE, 1'b1, 32'h09, 32'h0, 32'hffff_ff96, 1'b0, 2'd1, 32'h09);
    add_entry(1'b0, LSU_BYTE, 1'b0, 32'h09, 32'h0, 32'h0000_0096, 1'b0, 2'd1, 32'h09);
    add_entry(1'b0, LSU_HALF, 1'b1, 32'h08, 32'h0, 32'hffff_9648, 1'b0, 2'd1, 32'h08);
    // split loads across word boundaries
    add_entry(1'b0, LSU_WORD, 1'b0, 32'h11, 32'h0, 32'h5453_5251, 1'b0, 2'd2, 32'h14);
    add_entry(1'b0, LSU_WORD, 1'b0, 32'h16, 32'h0, 32'h5958_5756, 1'b0, 2'd2, 32'h18);
    add_entry(1'b0, LSU_WORD, 1'b0, 32'h1b, 32'h0, 32'h5e5d_5c5b, 1'b0, 2'd2, 32'h1c);
    add_entry(1'b0, LSU_HALF, 1'b0, 32'h13, 32'h0, 32'h0000_5453, 1'b0, 2'd2, 32'h14);
    // split stores, read back through both words
    add_entry(1'b1, LSU_WORD, 1'b0, 32'h21, 32'hc3b2_a190, 32'h0, 1'b0, 2'd2, 32'h24);
    add_entry(1'b0, LSU_WORD, 1'b0, 32'h20, 32'h0, 32'hb2a1_9060, 1'b0, 2'd1, 32'h20);
    add_entry(1'b0, LSU_WORD, 1'b0, 32'h24, 32'h0, 32'h6766_65c3, 1'b0, 2'd1, 32'h24);
    add_entry(1'b1, LSU_HALF, 1'b0, 32'h2b, 32'h0000_e1d2, 32'h0, 1'b0, 2'd2, 32'h2c);
    add_entry(1'b0, LSU_WORD, 1'b0, 32'h28, 32'h0, 32'hd26a_6968, 1'b0, 2'd1, 32'h28);
    add_entry(1'b0, LSU_WORD, 1'b0, 32'h2c, 32'h0, 32'h6f6e_6de1, 1'b0, 2'd1, 32'h2c);
    add_entry(1'b0, LSU_HALF, 1'b1, 32'h2b, 32'h0, 32'hffff_e1d2, 1'b0, 2'd2, 32'h2c);
    // bus errors, aligned, first part only, second part only, both parts
    add_entry(1'b0, LSU_WORD, 1'b0, 32'h30, 32'h0, 32'h0, 1'b1, 2'd1, 32'h30);
    add_entry(1'b1, LSU_BYTE, 1'b0, 32'h35, 32'h0000_0011, 32'h0, 1'b1, 2'd1, 32'h35);
    add_entry(1'b0, LSU_WORD, 1'b0, 32'h37, 32'h0, 32'h0, 1'b1, 2'd2, 32'h37);
    add_entry(1'b0, LSU_WORD, 1'b0, 32'h2e, 32'h0, 32'h0, 1'b1, 2'd2, 32'h30);
    add_entry(1'b1, LSU_HALF, 1'b0, 32'h33, 32'h0000_abcd, 32'h0, 1'b1, 2'd2, 32'h33);
    add_entry(1'b0, LSU_WORD, 1'b0, 32'h38, 32'h0, 32'h7b7a_7978, 1'b0, 2'd1, 32'h38);
  endfunction

  ////////////////////////////////////////
  // sequencing
  ////////////////////////////////////////

  task automatic check_reset();
    int unsigned errs_start;
    errs_start = err_cnt;
    check_flag("busy_o", busy, 1'b0);
    check_flag("data_req_o", data_req, 1'b0);
    check_flag("lsu_resp_valid_o", lsu_resp_valid, 1'b0);
    check_flag("lsu_rdata_valid_o", lsu_rdata_valid, 1'b0);
    check_flag("load_err_o", load_err, 1'b0);
    check_flag("store_err_o", store_err, 1'b0);
    check_flag("lsu_req_done_o", lsu_req_done, 1'b0);
    check_addr("addr_last_o", addr_last, '0);
    report_test("reset", errs_start);
  endtask

  task automatic run_entry(int idx);
    entry_t      e;
    int unsigned errs_start;
    int          gnt_start;
    e          = tbl[idx];
    errs_start = err_cnt;
    @(posedge clk);
    #1;
    // nothing may answer between two accesses
    check_count("lsu_resp_valid_o pulses", resp_cnt, resp_exp);
    gnt_start    = gnt_count;
    lsu_we       = e.we;
    lsu_type     = e.size;
    lsu_sign_ext = e.sign;
    lsu_addr     = e.addr;
    lsu_wdata    = e.wdata;
    lsu_req      = 1'b1;
    do @(negedge clk); while (!lsu_req_done);
    @(posedge clk);
    #1;
    lsu_req = 1'b0;
    do @(negedge clk); while (!lsu_resp_valid);
    resp_exp++;
    check_flag("lsu_rdata_valid_o", lsu_rdata_valid, !e.we && !e.err);
    check_flag("load_err_o", load_err, !e.we && e.err);
    check_flag("store_err_o", store_err, e.we && e.err);
    if (!e.we && !e.err) begin
      check_word("lsu_rdata_o", lsu_rdata, e.rdata);
    end
    check_addr("addr_last_o", addr_last, e.last);
    check_count("bus grants", gnt_count - gnt_start, int'(e.parts));
    report_test($sformatf("%s entry %0d", delay_en ? "delayed" : "direct", idx), errs_start);
  endtask

  initial begin
    int unsigned errs_start;
    lsu_req      = 1'b0;
    lsu_we       = 1'b0;
    lsu_type     = LSU_WORD;
    lsu_sign_ext = 1'b0;
    lsu_addr     = '0;
    lsu_wdata    = '0;
    delay_en     = 1'b0;
    build_table();
    // one extra allowance covers reset
    cycle_limit = (2 * tbl.size() + 1) * EntryCycles;
    wait (rst_n === 1'b1);
    @(negedge clk);
    check_reset();
    for (int phase = 0; phase < 2; phase++) begin
      @(negedge clk);
      delay_en = (phase == 1);
      // both passes start from the same memory image
      i_bus.fill_mem();
      for (int i = 0; i < tbl.size(); i++) begin
        run_entry(i);
      end
    end
    errs_start = err_cnt;
    repeat (4) @(posedge clk);
    #1;
    check_count("lsu_resp_valid_o pulses", resp_cnt, resp_exp);
    report_test("trailing responses", errs_start);
    $display("%0d tests passed, %0d failed", pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  // watchdog
  initial begin
    wait (cycle_limit != 0);
    repeat (cycle_limit) @(posedge clk);
    $display("timeout: the DUT did not finish the table within %0d cycles", cycle_limit);
    $display("Test FAILED");
    $finish;
  end

endmodule

// ==== vlog.f ====
rtl/lsu_pkg.sv
rtl/lsu_wdata_align.sv
rtl/lsu_rdata_align.sv
rtl/lsu_ctrl_fsm.sv
rtl/lsu_top.sv
bench/tb_clk_gen.sv
bench/lsu_bus_model.sv
bench/lsu_tb.sv
